//--- hw/tc_pkg.sv
// tensor-core dot-product package with opcode type and shared field widths
package tc_pkg;

    // operand interpretation, drives multiply, bias extension and clamp range
    typedef enum logic [0:0] {
        OP_SIGNED   = 1'b0,
        OP_UNSIGNED = 1'b1
    } tc_op_e;

    // bias and result width
    localparam int C_WIDTH = 16;

    // destination register index width
    localparam int IDXW_WIDTH = 8;

    // defaults for the top-level parameters
    localparam int SHAPE_K_DEF    = 8;
    localparam int IN_WIDTH_DEF   = 8;
    localparam int DEPTH_WARP_DEF = 3;
    localparam int FIFO_DEPTH_DEF = 4;

endpackage

//--- hw/tc_tag_pipe.sv
// tensor-core tag pipeline, carries valid, opcode, bias and tags and makes the global advance
`timescale 1ns/1ps

module tc_tag_pipe import tc_pkg::*; #(
    parameter int shape_k    = SHAPE_K_DEF,
    parameter int depth_warp = DEPTH_WARP_DEF
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  in_valid_i,
    input  tc_op_e                op_i,
    input  logic [C_WIDTH-1:0]    c_i,
    input  logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_i,
    input  logic [depth_warp-1:0] ctrl_warpid_i,
    input  logic                  fifo_full_i,
    output logic                  adv_o,
    output logic                  push_o,
    output tc_op_e                op_aligned_o,
    output logic [C_WIDTH-1:0]    c_aligned_o,
    output logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_o,
    output logic [depth_warp-1:0] ctrl_warpid_o
);

    // half-tree latency: product stage plus one stage per adder level
    localparam int lat = 1 + $clog2(shape_k / 2);

    // stage lat lines up with the combine output
    logic [lat:0]          valid_q;
    tc_op_e                op_q     [lat];
    logic [C_WIDTH-1:0]    c_q      [lat];
    logic [IDXW_WIDTH-1:0] idxw_q   [lat+1];
    logic [depth_warp-1:0] warpid_q [lat+1];

    // stall only when the last stage holds an item that has nowhere to go
    assign adv_o  = !(valid_q[lat] && fifo_full_i);
    assign push_o = valid_q[lat] && adv_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (adv_o) begin
            valid_q <= {valid_q[lat-1:0], in_valid_i};
        end
    end

    always_ff @(posedge clk) begin
        if (adv_o) begin
            op_q[0]     <= op_i;
            c_q[0]      <= c_i;
            idxw_q[0]   <= ctrl_reg_idxw_i;
            warpid_q[0] <= ctrl_warpid_i;
            for (int i = 1; i < lat; i++) begin
                op_q[i] <= op_q[i-1];
                c_q[i]  <= c_q[i-1];
            end
            for (int i = 1; i <= lat; i++) begin
                idxw_q[i]   <= idxw_q[i-1];
                warpid_q[i] <= warpid_q[i-1];
            end
        end
    end

    // opcode and bias meet the half sums at the combine input
    assign op_aligned_o = op_q[lat-1];
    assign c_aligned_o  = c_q[lat-1];

    // tags travel one stage further, next to the registered result
    assign ctrl_reg_idxw_o = idxw_q[lat];
    assign ctrl_warpid_o   = warpid_q[lat];

endmodule

//--- hw/tc_half_tree.sv
// tensor-core half tree, multiplies half of the operand pairs and reduces them in registered levels
`timescale 1ns/1ps

module tc_half_tree import tc_pkg::*; #(
    parameter int shape_k  = SHAPE_K_DEF,
    parameter int in_width = IN_WIDTH_DEF
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 adv_i,
    input  tc_op_e                               op_i,
    input  logic [(shape_k/2)*in_width-1:0]      a_i,
    input  logic [(shape_k/2)*in_width-1:0]      b_i,
    output logic [2*in_width+$clog2(shape_k/2)-1:0] sum_o
);

    localparam int half_k = shape_k / 2;
    localparam int levels = $clog2(half_k);
    localparam int prod_w = 2 * in_width;

    // opcode for the data held at each level, needed to extend the next add
    tc_op_e op_q [levels];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < levels; i++) begin
                op_q[i] <= OP_SIGNED;
            end
        end else if (adv_i) begin
            op_q[0] <= op_i;
            for (int i = 1; i < levels; i++) begin
                op_q[i] <= op_q[i-1];
            end
        end
    end

    genvar l;
    generate
        for (l = 0; l <= levels; l++) begin : g_lvl
            localparam int node_w = prod_w + l;
            localparam int nodes  = half_k >> l;

            logic [node_w-1:0] node_q [nodes];

            if (l == 0) begin : g_mul
                // signed or unsigned product, both fit exactly in prod_w bits
                always_ff @(posedge clk) begin
                    if (adv_i) begin
                        for (int n = 0; n < nodes; n++) begin
                            if (op_i == OP_SIGNED) begin
                                node_q[n] <= $signed(a_i[n*in_width +: in_width]) *
                                             $signed(b_i[n*in_width +: in_width]);
                            end else begin
                                node_q[n] <= a_i[n*in_width +: in_width] *
                                             b_i[n*in_width +: in_width];
                            end
                        end
                    end
                end
            end else begin : g_add
                logic sign_ext;

                // sign bit replicated only for signed data
                assign sign_ext = (op_q[l-1] == OP_SIGNED);

                // node n pairs with node n + nodes of the level below
                always_ff @(posedge clk) begin
                    if (adv_i) begin
                        for (int n = 0; n < nodes; n++) begin
                            node_q[n] <=
                                {sign_ext & g_lvl[l-1].node_q[n][node_w-2],
                                 g_lvl[l-1].node_q[n]} +
                                {sign_ext & g_lvl[l-1].node_q[n+nodes][node_w-2],
                                 g_lvl[l-1].node_q[n+nodes]};
                        end
                    end
                end
            end
        end
    endgenerate

    assign sum_o = g_lvl[levels].node_q[0];

endmodule

//--- hw/tc_combine.sv
// tensor-core combine stage, adds both half sums and the bias, then clamps to 16 bits
`timescale 1ns/1ps

module tc_combine import tc_pkg::*; #(
    parameter int shape_k  = SHAPE_K_DEF,
    parameter int in_width = IN_WIDTH_DEF
) (
    input  logic                                    clk,
    input  logic                                    adv_i,
    input  tc_op_e                                  op_i,
    input  logic [2*in_width+$clog2(shape_k/2)-1:0] sum_lo_i,
    input  logic [2*in_width+$clog2(shape_k/2)-1:0] sum_hi_i,
    input  logic [C_WIDTH-1:0]                      c_i,
    output logic [C_WIDTH-1:0]                      result_o,
    output logic                                    ovf_o
);

    localparam int sum_w = 2 * in_width + $clog2(shape_k / 2);
    // two carries for three addends, one more so unsigned values stay positive
    localparam int tot_w = ((sum_w > C_WIDTH) ? sum_w : C_WIDTH) + 3;

    localparam logic signed [tot_w-1:0] s_max = tot_w'(2 ** (C_WIDTH - 1) - 1);
    localparam logic signed [tot_w-1:0] s_min = tot_w'(-(2 ** (C_WIDTH - 1)));
    localparam logic signed [tot_w-1:0] u_max = tot_w'(2 ** C_WIDTH - 1);

    logic                     is_signed;
    logic signed [tot_w-1:0]  lo_ext;
    logic signed [tot_w-1:0]  hi_ext;
    logic signed [tot_w-1:0]  c_ext;
    logic signed [tot_w-1:0]  total;
    logic [C_WIDTH-1:0]       sat_val;
    logic                     sat_ovf;

    assign is_signed = (op_i == OP_SIGNED);

    assign lo_ext = {{(tot_w-sum_w){is_signed & sum_lo_i[sum_w-1]}}, sum_lo_i};
    assign hi_ext = {{(tot_w-sum_w){is_signed & sum_hi_i[sum_w-1]}}, sum_hi_i};
    assign c_ext  = {{(tot_w-C_WIDTH){is_signed & c_i[C_WIDTH-1]}}, c_i};

    assign total = lo_ext + hi_ext + c_ext;

    always_comb begin
        sat_val = total[C_WIDTH-1:0];
        sat_ovf = 1'b0;
        if (is_signed) begin
            if (total > s_max) begin
                sat_val = s_max[C_WIDTH-1:0];
                sat_ovf = 1'b1;
            end else if (total < s_min) begin
                sat_val = s_min[C_WIDTH-1:0];
                sat_ovf = 1'b1;
            end
        end else if (total > u_max) begin
            // unsigned total is never negative
            sat_val = u_max[C_WIDTH-1:0];
            sat_ovf = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            result_o <= sat_val;
            ovf_o    <= sat_ovf;
        end
    end

endmodule

//--- hw/tc_out_fifo.sv
// tensor-core output FIFO, show-ahead buffer for result, overflow flag and tags
`timescale 1ns/1ps

module tc_out_fifo import tc_pkg::*; #(
    parameter int depth_warp = DEPTH_WARP_DEF,
    parameter int fifo_depth = FIFO_DEPTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  push_i,
    input  logic [C_WIDTH-1:0]    result_i,
    input  logic                  ovf_i,
    input  logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_i,
    input  logic [depth_warp-1:0] ctrl_warpid_i,
    input  logic                  out_ready_i,
    output logic                  full_o,
    output logic                  out_valid_o,
    output logic [C_WIDTH-1:0]    result_o,
    output logic                  ovf_o,
    output logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_o,
    output logic [depth_warp-1:0] ctrl_warpid_o
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [C_WIDTH-1:0]    result_mem [fifo_depth];
    logic [fifo_depth-1:0] ovf_mem;
    logic [IDXW_WIDTH-1:0] idxw_mem   [fifo_depth];
    logic [depth_warp-1:0] warpid_mem [fifo_depth];
    logic [ptr_w-1:0]      wr_ptr_q;
    logic [ptr_w-1:0]      rd_ptr_q;
    logic [cnt_w-1:0]      count_q;
    logic                  pop;

    // wrap explicitly so any depth works
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_valid_o = (count_q != '0);
    assign full_o      = (count_q == cnt_w'(fifo_depth));
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // simultaneous push and pop keeps the count
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            result_mem[wr_ptr_q] <= result_i;
            ovf_mem[wr_ptr_q]    <= ovf_i;
            idxw_mem[wr_ptr_q]   <= ctrl_reg_idxw_i;
            warpid_mem[wr_ptr_q] <= ctrl_warpid_i;
        end
    end

    // head entry shown directly
    assign result_o        = result_mem[rd_ptr_q];
    assign ovf_o           = ovf_mem[rd_ptr_q];
    assign ctrl_reg_idxw_o = idxw_mem[rd_ptr_q];
    assign ctrl_warpid_o   = warpid_mem[rd_ptr_q];

endmodule

//--- hw/tc_dot_product.sv
// tensor-core dot-product engine, integer multiply-reduce with bias, clamp and output buffer
`timescale 1ns/1ps

module tc_dot_product import tc_pkg::*; #(
    parameter int shape_k    = SHAPE_K_DEF,
    parameter int in_width   = IN_WIDTH_DEF,
    parameter int depth_warp = DEPTH_WARP_DEF,
    parameter int fifo_depth = FIFO_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [shape_k*in_width-1:0]   a_i,
    input  logic [shape_k*in_width-1:0]   b_i,
    input  logic [C_WIDTH-1:0]            c_i,
    input  tc_op_e                        op_i,
    input  logic [IDXW_WIDTH-1:0]         ctrl_reg_idxw_i,
    input  logic [depth_warp-1:0]         ctrl_warpid_i,
    input  logic                          in_valid_i,
    input  logic                          out_ready_i,
    output logic                          in_ready_o,
    output logic                          out_valid_o,
    output logic [C_WIDTH-1:0]            result_o,
    output logic                          ovf_o,
    output logic [IDXW_WIDTH-1:0]         ctrl_reg_idxw_o,
    output logic [depth_warp-1:0]         ctrl_warpid_o
);

    localparam int half_w = (shape_k / 2) * in_width;
    localparam int sum_w  = 2 * in_width + $clog2(shape_k / 2);

    logic                  adv;
    logic                  push;
    logic                  fifo_full;
    tc_op_e                op_aligned;
    logic [C_WIDTH-1:0]    c_aligned;
    logic [IDXW_WIDTH-1:0] pipe_idxw;
    logic [depth_warp-1:0] pipe_warpid;
    logic [sum_w-1:0]      sum_lo;
    logic [sum_w-1:0]      sum_hi;
    logic [C_WIDTH-1:0]    comb_result;
    logic                  comb_ovf;

    // new requests enter whenever the pipeline moves
    assign in_ready_o = adv;

    tc_tag_pipe #(
        .shape_k    (shape_k),
        .depth_warp (depth_warp)
    ) u_tag_pipe (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .op_i            (op_i),
        .c_i             (c_i),
        .ctrl_reg_idxw_i (ctrl_reg_idxw_i),
        .ctrl_warpid_i   (ctrl_warpid_i),
        .fifo_full_i     (fifo_full),
        .adv_o           (adv),
        .push_o          (push),
        .op_aligned_o    (op_aligned),
        .c_aligned_o     (c_aligned),
        .ctrl_reg_idxw_o (pipe_idxw),
        .ctrl_warpid_o   (pipe_warpid)
    );

    // products 0 .. shape_k/2-1
    tc_half_tree #(
        .shape_k  (shape_k),
        .in_width (in_width)
    ) u_half_lo (
        .clk     (clk),
        .reset_i (reset_i),
        .adv_i   (adv),
        .op_i    (op_i),
        .a_i     (a_i[half_w-1:0]),
        .b_i     (b_i[half_w-1:0]),
        .sum_o   (sum_lo)
    );

    // products shape_k/2 .. shape_k-1
    tc_half_tree #(
        .shape_k  (shape_k),
        .in_width (in_width)
    ) u_half_hi (
        .clk     (clk),
        .reset_i (reset_i),
        .adv_i   (adv),
        .op_i    (op_i),
        .a_i     (a_i[shape_k*in_width-1:half_w]),
        .b_i     (b_i[shape_k*in_width-1:half_w]),
        .sum_o   (sum_hi)
    );

    tc_combine #(
        .shape_k  (shape_k),
        .in_width (in_width)
    ) u_combine (
        .clk      (clk),
        .adv_i    (adv),
        .op_i     (op_aligned),
        .sum_lo_i (sum_lo),
        .sum_hi_i (sum_hi),
        .c_i      (c_aligned),
        .result_o (comb_result),
        .ovf_o    (comb_ovf)
    );

    tc_out_fifo #(
        .depth_warp (depth_warp),
        .fifo_depth (fifo_depth)
    ) u_out_fifo (
        .clk             (clk),
        .reset_i         (reset_i),
        .push_i          (push),
        .result_i        (comb_result),
        .ovf_i           (comb_ovf),
        .ctrl_reg_idxw_i (pipe_idxw),
        .ctrl_warpid_i   (pipe_warpid),
        .out_ready_i     (out_ready_i),
        .full_o          (fifo_full),
        .out_valid_o     (out_valid_o),
        .result_o        (result_o),
        .ovf_o           (ovf_o),
        .ctrl_reg_idxw_o (ctrl_reg_idxw_o),
        .ctrl_warpid_o   (ctrl_warpid_o)
    );

endmodule

//--- dv/tc_dot_product_assert.sv
// output handshake assertions for the tensor-core dot-product engine
`timescale 1ns/1ps

module tc_dot_product_assert import tc_pkg::*; #(
    parameter int depth_warp = DEPTH_WARP_DEF
) (
    input logic                  clk,
    input logic                  reset_i,
    input logic                  in_ready_o,
    input logic                  out_valid_o,
    input logic                  out_ready_i,
    input logic [C_WIDTH-1:0]    result_o,
    input logic                  ovf_o,
    input logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_o,
    input logic [depth_warp-1:0] ctrl_warpid_o
);

    // buffer comes up empty
    a_reset_empty: assert property (@(posedge clk) reset_i |=> !out_valid_o)
        else $error("out_valid_o high in the cycle after reset");

    // stalled head entry keeps its data
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(ovf_o)
            && $stable(ctrl_reg_idxw_o) && $stable(ctrl_warpid_o))
        else $error("output changed while stalled");

    // a consumer that keeps taking results frees the pipeline
    a_no_block: assert property (@(posedge clk) disable iff (reset_i)
        out_ready_i && $past(out_ready_i) && $past(out_ready_i, 2) |-> in_ready_o)
        else $error("in_ready_o low while out_ready_i held high");

endmodule

bind tc_dot_product tc_dot_product_assert #(
    .depth_warp (depth_warp)
) u_assert (
    .clk             (clk),
    .reset_i         (reset_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .result_o        (result_o),
    .ovf_o           (ovf_o),
    .ctrl_reg_idxw_o (ctrl_reg_idxw_o),
    .ctrl_warpid_o   (ctrl_warpid_o)
);

//--- dv/tb_tc_dot_product.sv
// testbench for the tensor-core dot-product engine with directed tests against a reference model
`timescale 1ns/1ps

module tb_tc_dot_product import tc_pkg::*; ();

    localparam int shape_k    = SHAPE_K_DEF;
    localparam int in_width   = IN_WIDTH_DEF;
    localparam int depth_warp = DEPTH_WARP_DEF;
    localparam int fifo_depth = FIFO_DEPTH_DEF;
    localparam int vec_w      = shape_k * in_width;
    // product stage, adder levels, combine register and FIFO write
    localparam int latency    = 1 + $clog2(shape_k / 2) + 2;
    // pipeline stages plus buffer entries
    localparam int capacity   = latency - 1 + fifo_depth;
    localparam int exp_w      = 1 + C_WIDTH + IDXW_WIDTH + depth_warp;
    localparam int wait_limit = 400;

    logic                  clk;
    logic                  reset_i;
    logic [vec_w-1:0]      a_i;
    logic [vec_w-1:0]      b_i;
    logic [C_WIDTH-1:0]    c_i;
    tc_op_e                op_i;
    logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_i;
    logic [depth_warp-1:0] ctrl_warpid_i;
    logic                  in_valid_i;
    logic                  out_ready_i;
    logic                  in_ready_o;
    logic                  out_valid_o;
    logic [C_WIDTH-1:0]    result_o;
    logic                  ovf_o;
    logic [IDXW_WIDTH-1:0] ctrl_reg_idxw_o;
    logic [depth_warp-1:0] ctrl_warpid_o;

    logic [31:0]      lfsr_state;
    logic [exp_w-1:0] exp_q [$];

    tc_dot_product #(
        .shape_k    (shape_k),
        .in_width   (in_width),
        .depth_warp (depth_warp),
        .fifo_depth (fifo_depth)
    ) u_tc_dot_product (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [63:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    // expected {ovf, result} as the biased dot product clamped to the opcode's range
    function automatic logic [C_WIDTH:0] ref_dot(input logic [vec_w-1:0] a,
                                               input logic [vec_w-1:0] b,
                                               input logic [C_WIDTH-1:0] c,
                                               input tc_op_e op);
        longint acc;
        longint ea;
        longint eb;
        acc = (op == OP_SIGNED) ? longint'($signed(c)) : longint'(c);
        for (int i = 0; i < shape_k; i++) begin
            if (op == OP_SIGNED) begin
                ea = longint'($signed(a[i*in_width +: in_width]));
                eb = longint'($signed(b[i*in_width +: in_width]));
            end else begin
                ea = longint'(a[i*in_width +: in_width]);
                eb = longint'(b[i*in_width +: in_width]);
            end
            acc = acc + ea * eb;
        end
        if (op == OP_SIGNED) begin
            if (acc > 32767) return {1'b1, 16'h7fff};
            if (acc < -32768) return {1'b1, 16'h8000};
        end else if (acc > 65535) begin
            return {1'b1, 16'hffff};
        end
        return {1'b0, acc[C_WIDTH-1:0]};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error("a checked value did not match");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_random_request();
        a_i             = rand_bits(vec_w);
        b_i             = rand_bits(vec_w);
        c_i             = C_WIDTH'(rand_bits(C_WIDTH));
        op_i            = tc_op_e'(rand_bit());
        ctrl_reg_idxw_i = IDXW_WIDTH'(rand_bits(IDXW_WIDTH));
        ctrl_warpid_i   = depth_warp'(rand_bits(depth_warp));
    endtask

    task automatic push_expected();
        logic [C_WIDTH:0] r;
        r = ref_dot(a_i, b_i, c_i, op_i);
        exp_q.push_back({r, ctrl_reg_idxw_i, ctrl_warpid_i});
    endtask

    // compare the FIFO head with the oldest expected item
    task automatic check_head();
        logic [exp_w-1:0] e;
        if (exp_q.size() == 0) begin
            stop_on_error("out_valid_o was high with no request outstanding");
        end else begin
            e = exp_q.pop_front();
            check("result_o", 32'(result_o), 32'(e[exp_w-2 -: C_WIDTH]));
            check("ovf_o", 32'(ovf_o), 32'(e[exp_w-1]));
            check("ctrl_reg_idxw_o", 32'(ctrl_reg_idxw_o), 32'(e[depth_warp +: IDXW_WIDTH]));
            check("ctrl_warpid_o", 32'(ctrl_warpid_o), 32'(e[depth_warp-1:0]));
        end
    endtask

    // one clock with both handshakes
    // outputs depend only on registered state
    task automatic run_cycle(input logic offer, input logic ready, output logic taken);
        in_valid_i  = offer;
        out_ready_i = ready;
        taken = offer && in_ready_o;
        if (taken) push_expected();
        if (out_valid_o && ready) check_head();
        next_cycle();
    endtask

    // counts the accepting edge as cycle 1
    task automatic wait_out_valid(output int cycles);
        cycles = 1;
        while (!out_valid_o) begin
            next_cycle();
            cycles++;
            if (cycles > wait_limit) stop_on_error("timed out waiting for out_valid_o");
        end
    endtask

    task automatic drain_outputs(input logic random_ready);
        int   guard;
        logic taken;
        guard = 0;
        while (exp_q.size() != 0) begin
            run_cycle(1'b0, random_ready ? rand_bit() : 1'b1, taken);
            guard++;
            if (guard > wait_limit) stop_on_error("timed out draining the output FIFO");
        end
        check("out_valid_o", 32'(out_valid_o), 32'd0);
    endtask

    task automatic send_one(input logic [vec_w-1:0] a, input logic [vec_w-1:0] b,
                            input logic [C_WIDTH-1:0] c, input tc_op_e op,
                            input logic [C_WIDTH-1:0] exp_res, input logic exp_ovf);
        int   cycles;
        logic taken;
        a_i             = a;
        b_i             = b;
        c_i             = c;
        op_i            = op;
        ctrl_reg_idxw_i = IDXW_WIDTH'(rand_bits(IDXW_WIDTH));
        ctrl_warpid_i   = depth_warp'(rand_bits(depth_warp));
        run_cycle(1'b1, 1'b1, taken);
        check("in_ready_o", 32'(taken), 32'd1);
        in_valid_i = 1'b0;
        wait_out_valid(cycles);
        check("latency", 32'(cycles), 32'(latency));
        check("result_o", 32'(result_o), 32'(exp_res));
        check("ovf_o", 32'(ovf_o), 32'(exp_ovf));
        run_cycle(1'b0, 1'b1, taken);
        check("out_valid_o", 32'(out_valid_o), 32'd0);
    endtask

    task automatic single_signed_request();
        check("out_valid_o", 32'(out_valid_o), 32'd0);
        check("in_ready_o", 32'(in_ready_o), 32'd1);
        // products sum to 23 before the bias of -10
        send_one(64'h0102_0304_05fe_fd06, 64'h0302_01ff_0207_0104, 16'hfff6, OP_SIGNED,
                 16'h000d, 1'b0);
    endtask

    task automatic signed_saturation();
        send_one({shape_k{8'h7f}}, {shape_k{8'h7f}}, 16'h7fff, OP_SIGNED, 16'h7fff, 1'b1);
        send_one({shape_k{8'h7f}}, {shape_k{8'h80}}, 16'h8000, OP_SIGNED, 16'h8000, 1'b1);
    endtask

    task automatic unsigned_operands();
        send_one({shape_k{8'hff}}, {shape_k{8'hff}}, 16'hffff, OP_UNSIGNED, 16'hffff, 1'b1);
        // 8 * 128 * 2 + 4096 with operands that are negative when read as signed
        send_one({shape_k{8'h80}}, {shape_k{8'h02}}, 16'h1000, OP_UNSIGNED, 16'h1800, 1'b0);
    endtask

    task automatic back_pressure();
        int   sent;
        int   guard;
        logic taken;
        sent  = 0;
        guard = 0;
        load_random_request();
        // consumer stalled until the engine refuses requests
        while (in_ready_o) begin
            run_cycle(1'b1, 1'b0, taken);
            if (taken) begin
                sent++;
                load_random_request();
            end
            guard++;
            if (guard > wait_limit) stop_on_error("timed out waiting for in_ready_o to fall");
        end
        check("accepted before stall", 32'(sent), 32'(capacity));
        for (int i = 0; i < 3; i++) begin
            run_cycle(1'b1, 1'b0, taken);
            check("in_ready_o", 32'(taken), 32'd0);
            check("out_valid_o", 32'(out_valid_o), 32'd1);
        end
        guard = 0;
        while (sent < 10) begin
            run_cycle(1'b1, 1'b1, taken);
            if (taken) begin
                sent++;
                load_random_request();
            end
            guard++;
            if (guard > wait_limit) stop_on_error("timed out offering requests after the stall");
        end
        in_valid_i = 1'b0;
        drain_outputs(1'b0);
    endtask

    task automatic streaming();
        int   sent;
        int   guard;
        logic taken;
        sent  = 0;
        guard = 0;
        load_random_request();
        while (sent < 40) begin
            run_cycle(1'b1, rand_bit(), taken);
            if (taken) begin
                sent++;
                load_random_request();
            end
            guard++;
            if (guard > wait_limit) stop_on_error("timed out streaming requests");
        end
        in_valid_i = 1'b0;
        drain_outputs(1'b1);
    endtask

    initial begin
        lfsr_state      = 32'd68395;
        reset_i         = 1'b1;
        in_valid_i      = 1'b0;
        out_ready_i     = 1'b0;
        a_i             = '0;
        b_i             = '0;
        c_i             = '0;
        op_i            = OP_SIGNED;
        ctrl_reg_idxw_i = '0;
        ctrl_warpid_i   = '0;
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        single_signed_request();
        signed_saturation();
        unsigned_operands();
        back_pressure();
        streaming();
        $display("sim passed");
        $finish;
    end

endmodule

//--- project.f
hw/tc_pkg.sv
hw/tc_tag_pipe.sv
hw/tc_half_tree.sv
hw/tc_combine.sv
hw/tc_out_fifo.sv
hw/tc_dot_product.sv
dv/tc_dot_product_assert.sv
dv/tb_tc_dot_product.sv

//--- run.sh
#!/bin/sh
# build and run the dot-product testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tc_dot_product -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
